//--- design/combined_vc_sw_alloc.sv
`timescale 1ns/1ps

module combined_vc_sw_alloc #(
    parameter int  P  = 4,
    parameter int  V  = 2,
    localparam int PW = (P > 1) ? $clog2(P) : 1,
    localparam int VW = (V > 1) ? $clog2(V) : 1
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic [P*V-1:0]    ivc_req,
    input  logic [P*V*PW-1:0] ivc_dest,
    input  logic [P*V-1:0]    ivc_is_head,
    input  logic [P*V-1:0]    ivc_is_tail,
    input  logic [P*V-1:0]    ivc_ovc_assigned,
    input  logic [P-1:0]      out_busy,
    input  logic [P-1:0]      ovc_release_valid,
    input  logic [P*VW-1:0]   ovc_release_num,
    output logic [P*V-1:0]    sw_grant_ivc,
    output logic [P*VW-1:0]   granted_ovc,
    output logic [P-1:0]      xbar_sel_valid,
    output logic [P*PW-1:0]   xbar_sel_in,
    output logic [P*VW-1:0]   xbar_ovc
);

    logic [P*V-1:0] need_vc;        // Head still without an output VC.
    logic [P*V-1:0] mreq;
    logic [P*V-1:0] first_grant;
    logic [P-1:0]   in_win;
    logic [P-1:0]   win_new;        // Input winner is a head taking a new VC.
    logic [PW-1:0]  win_dest [P];
    logic [VW-1:0]  win_ovc  [P];
    logic [P-1:0]   req2     [P];   // Indexed by output, then input.
    logic [P-1:0]   g2       [P];
    logic [V-1:0]   ovc_alloc [P];
    logic [VW-1:0]  free_idx [P];
    logic [P-1:0]   free_any;
    logic [P-1:0]   head_grant;
    logic [VW-1:0]  ovc_rec  [P*V];
    logic [P-1:0]   gto      [P];
    logic [V-1:0]   held     [P];   // Output VCs of open packets, by output.

    always_comb begin
        for (int o = 0; o < P; o++) begin
            free_any[o] = ~&ovc_alloc[o];
            free_idx[o] = '0;
            for (int k = V - 1; k >= 0; k--)
                if (!ovc_alloc[o][k])
                    free_idx[o] = VW'(k);               // Lowest free VC.
        end
    end

    // A grant in flight counts as busy until the output stage picks it up.
    always_comb begin
        logic [PW-1:0] dst;
        for (int i = 0; i < P * V; i++) begin
            dst        = ivc_dest[i*PW +: PW];
            need_vc[i] = ivc_is_head[i] && !ivc_ovc_assigned[i];
            mreq[i]    = ivc_req[i] && !sw_grant_ivc[i] && !out_busy[dst]
                         && !xbar_sel_valid[dst] && (!need_vc[i] || free_any[dst]);
        end
    end

    for (genvar p = 0; p < P; p++) begin : g_in_arb
        rr_arbiter #(.N(V)) i_arb (
            .clk     (clk),
            .rst_n   (rst_n),
            .request (mreq[p*V +: V]),
            .accept  (in_win[p]),
            .grant   (first_grant[p*V +: V])
        );
    end

    always_comb begin
        for (int p = 0; p < P; p++) begin
            win_dest[p] = '0;
            win_ovc[p]  = '0;
            win_new[p]  = 1'b0;
            for (int v = 0; v < V; v++) begin
                if (first_grant[p*V+v]) begin
                    win_dest[p] = ivc_dest[(p*V+v)*PW +: PW];
                    win_new[p]  = need_vc[p*V+v];
                    win_ovc[p]  = need_vc[p*V+v] ? free_idx[win_dest[p]] : ovc_rec[p*V+v];
                end
            end
        end
        for (int o = 0; o < P; o++)
            for (int p = 0; p < P; p++)
                req2[o][p] = |first_grant[p*V +: V] && (win_dest[p] == PW'(o));
    end

    for (genvar o = 0; o < P; o++) begin : g_out_arb
        rr_arbiter #(.N(P)) i_arb (
            .clk     (clk),
            .rst_n   (rst_n),
            .request (req2[o]),
            .accept  (|req2[o]),
            .grant   (g2[o])
        );
    end

    always_comb begin
        in_win = '0;
        for (int o = 0; o < P; o++) begin
            in_win     = in_win | g2[o];
            head_grant[o] = |(g2[o] & win_new);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sw_grant_ivc   <= '0;
            xbar_sel_valid <= '0;
            for (int o = 0; o < P; o++)
                ovc_alloc[o] <= '0;
        end else begin
            for (int p = 0; p < P; p++)
                sw_grant_ivc[p*V +: V] <= in_win[p] ? first_grant[p*V +: V] : '0;
            for (int o = 0; o < P; o++) begin
                xbar_sel_valid[o] <= |req2[o];
                if (ovc_release_valid[o])
                    ovc_alloc[o][ovc_release_num[o*VW +: VW]] <= 1'b0;
                if (head_grant[o])
                    ovc_alloc[o][free_idx[o]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < P; p++) begin
            granted_ovc[p*VW +: VW] <= win_ovc[p];
            for (int v = 0; v < V; v++)
                if (in_win[p] && first_grant[p*V+v] && need_vc[p*V+v])
                    ovc_rec[p*V+v] <= win_ovc[p];      // Kept for the body flits.
        end
        for (int o = 0; o < P; o++) begin
            for (int p = 0; p < P; p++) begin
                if (g2[o][p]) begin
                    xbar_sel_in[o*PW +: PW] <= PW'(p);
                    xbar_ovc[o*VW +: VW]    <= win_ovc[p];
                end
            end
        end
    end

    // Inputs holding a registered grant, sorted by the output they address.
    always_comb begin
        for (int o = 0; o < P; o++)
            gto[o] = '0;
        for (int i = 0; i < P * V; i++)
            if (sw_grant_ivc[i])
                gto[ivc_dest[i*PW +: PW]][i / V] = 1'b1;
    end

    // Output VCs still in use, rebuilt from the per-VC records of open packets.
    always_comb begin
        for (int o = 0; o < P; o++)
            held[o] = '0;
        for (int i = 0; i < P * V; i++)
            if (ivc_ovc_assigned[i])
                held[ivc_dest[i*PW +: PW]][ovc_rec[i]] = 1'b1;
    end

    for (genvar o = 0; o < P; o++) begin : g_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            head_grant[o] |-> !held[o][free_idx[o]])
            else $error("output %0d: head granted an allocated VC", o);
        assert property (@(posedge clk) disable iff (!rst_n) $onehot0(gto[o]))
            else $error("output %0d: granted to several inputs", o);
    end

    // Body and tail flits only request once their head holds a VC.
    for (genvar i = 0; i < P * V; i++) begin : g_tail_chk
        assert property (@(posedge clk) disable iff (!rst_n)
            ivc_req[i] && ivc_is_tail[i] && !ivc_is_head[i] |-> ivc_ovc_assigned[i])
            else $error("ivc %0d: tail without an output VC", i);
    end

endmodule

//--- design/crossbar_output_stage.sv
`timescale 1ns/1ps

module crossbar_output_stage #(
    parameter int  P      = 4,
    parameter int  V      = 2,
    parameter int  DATA_W = 16,
    localparam int PW     = (P > 1) ? $clog2(P) : 1,
    localparam int VW     = (V > 1) ? $clog2(V) : 1,
    localparam int KW     = noc_flit_pkg::FLIT_KIND_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [P-1:0]          xbar_sel_valid,
    input  logic [P*PW-1:0]       xbar_sel_in,
    input  logic [P*VW-1:0]       xbar_ovc,
    input  logic [P*V*KW-1:0]     buf_kind,
    input  logic [P*V*DATA_W-1:0] buf_data,
    input  logic [P*V-1:0]        sw_grant_ivc,
    output logic [P-1:0]          out_busy,
    output logic [P-1:0]          ovc_release_valid,
    output logic [P*VW-1:0]       ovc_release_num,
    output logic [P-1:0]          out_req,
    input  logic [P-1:0]          out_ack,
    output logic [P*VW-1:0]       out_vc,
    output logic [P*KW-1:0]       out_kind,
    output logic [P*DATA_W-1:0]   out_data
);

    logic [KW-1:0]     sel_kind [P];
    logic [DATA_W-1:0] sel_data [P];

    // Flit of the granted VC of each input port.
    always_comb begin
        for (int p = 0; p < P; p++) begin
            sel_kind[p] = '0;
            sel_data[p] = '0;
            for (int v = 0; v < V; v++) begin
                if (sw_grant_ivc[p*V+v]) begin
                    sel_kind[p] = buf_kind[(p*V+v)*KW +: KW];
                    sel_data[p] = buf_data[(p*V+v)*DATA_W +: DATA_W];
                end
            end
        end
    end

    for (genvar o = 0; o < P; o++) begin : g_out
        noc_alloc_pkg::link_state_e tx_state;
        noc_flit_pkg::flit_kind_e   kind_q;
        logic [VW-1:0]              vc_q;
        logic [DATA_W-1:0]          data_q;
        logic [PW-1:0]              src;

        assign src = xbar_sel_in[o*PW +: PW];

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                tx_state <= noc_alloc_pkg::LINK_IDLE;
            end else begin
                case (tx_state)
                    noc_alloc_pkg::LINK_IDLE:
                        if (xbar_sel_valid[o])
                            tx_state <= noc_alloc_pkg::LINK_REQ;
                    noc_alloc_pkg::LINK_REQ:
                        if (out_ack[o])
                            tx_state <= noc_alloc_pkg::LINK_DROP;   // Req drops next cycle.
                    default:
                        if (!out_ack[o])
                            tx_state <= noc_alloc_pkg::LINK_IDLE;
                endcase
            end
        end

        always_ff @(posedge clk) begin
            if (xbar_sel_valid[o]) begin
                vc_q   <= xbar_ovc[o*VW +: VW];
                kind_q <= noc_flit_pkg::flit_kind_e'(sel_kind[src]);
                data_q <= sel_data[src];
            end
        end

        assign out_req[o]                   = (tx_state == noc_alloc_pkg::LINK_REQ);
        assign out_busy[o]                  = (tx_state != noc_alloc_pkg::LINK_IDLE);
        assign out_vc[o*VW +: VW]           = vc_q;
        assign out_kind[o*KW +: KW]         = kind_q;
        assign out_data[o*DATA_W +: DATA_W] = data_q;

        // Tail accepted downstream frees its output VC.
        assign ovc_release_valid[o] = out_req[o] && out_ack[o]
                                      && noc_flit_pkg::kind_is_tail(kind_q);
        assign ovc_release_num[o*VW +: VW] = vc_q;
    end

endmodule

//--- design/ivc_request_stage.sv
`timescale 1ns/1ps

module ivc_request_stage #(
    parameter int  P      = 4,
    parameter int  V      = 2,
    parameter int  DATA_W = 16,
    localparam int PW     = (P > 1) ? $clog2(P) : 1,
    localparam int VW     = (V > 1) ? $clog2(V) : 1,
    localparam int KW     = noc_flit_pkg::FLIT_KIND_W
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic [P-1:0]          in_req,
    output logic [P-1:0]          in_ack,
    input  logic [P*VW-1:0]       in_vc,
    input  logic [P*PW-1:0]       in_dest,
    input  logic [P*KW-1:0]       in_kind,
    input  logic [P*DATA_W-1:0]   in_data,
    input  logic [P*V-1:0]        sw_grant_ivc,
    input  logic [P*VW-1:0]       granted_ovc,
    output logic [P*V-1:0]        ivc_req,
    output logic [P*V*PW-1:0]     ivc_dest,
    output logic [P*V-1:0]        ivc_is_head,
    output logic [P*V-1:0]        ivc_is_tail,
    output logic [P*V-1:0]        ivc_ovc_assigned,
    output logic [P*V*KW-1:0]     buf_kind,
    output logic [P*V*DATA_W-1:0] buf_data
);

    for (genvar p = 0; p < P; p++) begin : g_port
        noc_alloc_pkg::link_state_e rx_state;
        noc_flit_pkg::flit_kind_e   kind;
        logic [VW-1:0]              vc;
        logic                       capture;

        assign vc      = in_vc[p*VW +: VW];
        assign kind    = noc_flit_pkg::flit_kind_e'(in_kind[p*KW +: KW]);
        assign capture = (rx_state == noc_alloc_pkg::LINK_IDLE) && in_req[p]
                         && !ivc_req[p*V + vc];                // Target buffer must be empty.
        assign in_ack[p] = (rx_state == noc_alloc_pkg::LINK_REQ);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                rx_state <= noc_alloc_pkg::LINK_IDLE;
            end else if (capture) begin
                rx_state <= noc_alloc_pkg::LINK_REQ;
            end else if (rx_state == noc_alloc_pkg::LINK_REQ && !in_req[p]) begin
                rx_state <= noc_alloc_pkg::LINK_IDLE;          // Ack falls a cycle after req.
            end
        end

        // Routing is outside the router, so the source must never loop back.
        assert property (@(posedge clk) disable iff (!rst_n)
            capture && noc_flit_pkg::kind_is_head(kind) |-> in_dest[p*PW +: PW] != PW'(p))
            else $error("port %0d: head addressed to its own port", p);

        for (genvar v = 0; v < V; v++) begin : g_vc
            localparam int I = p * V + v;
            noc_alloc_pkg::ivc_state_e state;
            noc_flit_pkg::flit_kind_e  kind_q;
            logic [DATA_W-1:0]         data_q;
            logic [PW-1:0]             dest_q;
            logic [VW-1:0]             ovc_q;
            logic                      valid_q;
            logic                      wr;
            logic                      pop;

            assign wr  = capture && (vc == VW'(v));
            assign pop = sw_grant_ivc[I];

            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    valid_q <= 1'b0;
                    state   <= noc_alloc_pkg::IVC_IDLE;
                end else if (wr) begin
                    valid_q <= 1'b1;
                    if (noc_flit_pkg::kind_is_head(kind))
                        state <= noc_alloc_pkg::IVC_WAIT_VC;
                end else if (pop) begin
                    valid_q <= 1'b0;
                    if (noc_flit_pkg::kind_is_tail(kind_q))
                        state <= noc_alloc_pkg::IVC_IDLE;      // Packet closed.
                    else if (state == noc_alloc_pkg::IVC_WAIT_VC)
                        state <= noc_alloc_pkg::IVC_ACTIVE;
                end
            end

            always_ff @(posedge clk) begin
                if (wr) begin
                    kind_q <= kind;
                    data_q <= in_data[p*DATA_W +: DATA_W];
                    if (noc_flit_pkg::kind_is_head(kind))
                        dest_q <= in_dest[p*PW +: PW];         // Body flits reuse it.
                end
                if (pop && state == noc_alloc_pkg::IVC_WAIT_VC)
                    ovc_q <= granted_ovc[p*VW +: VW];
            end

            assign ivc_req[I]                = valid_q;
            assign ivc_dest[I*PW +: PW]      = dest_q;
            assign ivc_is_head[I]            = noc_flit_pkg::kind_is_head(kind_q);
            assign ivc_is_tail[I]            = noc_flit_pkg::kind_is_tail(kind_q);
            assign ivc_ovc_assigned[I]       = (state == noc_alloc_pkg::IVC_ACTIVE);
            assign buf_kind[I*KW +: KW]      = kind_q;
            assign buf_data[I*DATA_W +: DATA_W] = data_q;

            assert property (@(posedge clk) disable iff (!rst_n)
                wr && !noc_flit_pkg::kind_is_head(kind) |-> state != noc_alloc_pkg::IVC_IDLE)
                else $error("port %0d vc %0d: body or tail without a head", p, v);

            // Later flits of a packet must leave on the VC the head was given.
            assert property (@(posedge clk) disable iff (!rst_n)
                pop && state == noc_alloc_pkg::IVC_ACTIVE |-> granted_ovc[p*VW +: VW] == ovc_q)
                else $error("port %0d vc %0d: output VC changed inside a packet", p, v);
        end
    end

endmodule

//--- design/noc_alloc_pkg.sv
package noc_alloc_pkg;

    // Packet state of one input VC.
    typedef enum logic [1:0] {
        IVC_IDLE    = 2'd0,         // No packet open.
        IVC_WAIT_VC = 2'd1,         // Head buffered, no output VC yet.
        IVC_ACTIVE  = 2'd2          // Output VC held until the tail pops.
    } ivc_state_e;

    // Four-phase link, shared by receivers and senders.
    typedef enum logic [1:0] {
        LINK_IDLE = 2'd0,           // Waiting for a flit.
        LINK_REQ  = 2'd1,           // Req or ack high.
        LINK_DROP = 2'd2            // Req dropped, waiting for ack to fall.
    } link_state_e;

endpackage

//--- design/noc_flit_pkg.sv
package noc_flit_pkg;

    // Kind field travels next to vc, dest and data on every link.
    localparam int FLIT_KIND_W = 2;

    typedef enum logic [FLIT_KIND_W-1:0] {
        FLIT_HEAD   = 2'd0,         // Opens a packet, carries the destination.
        FLIT_BODY   = 2'd1,
        FLIT_TAIL   = 2'd2,         // Closes a packet.
        FLIT_SINGLE = 2'd3          // Head and tail in one flit.
    } flit_kind_e;

    // A single flit counts as both head and tail.
    function automatic logic kind_is_head(flit_kind_e kind);
        return (kind == FLIT_HEAD) || (kind == FLIT_SINGLE);
    endfunction

    function automatic logic kind_is_tail(flit_kind_e kind);
        return (kind == FLIT_TAIL) || (kind == FLIT_SINGLE);
    endfunction

endpackage

//--- design/router_alloc_top.sv
`timescale 1ns/1ps

module router_alloc_top #(
    parameter int  P      = 4,
    parameter int  V      = 2,
    parameter int  DATA_W = 16,
    localparam int PW     = (P > 1) ? $clog2(P) : 1,
    localparam int VW     = (V > 1) ? $clog2(V) : 1,
    localparam int KW     = noc_flit_pkg::FLIT_KIND_W
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic [P-1:0]        in_req,
    output logic [P-1:0]        in_ack,
    input  logic [P*VW-1:0]     in_vc,
    input  logic [P*PW-1:0]     in_dest,
    input  logic [P*KW-1:0]     in_kind,
    input  logic [P*DATA_W-1:0] in_data,
    output logic [P-1:0]        out_req,
    input  logic [P-1:0]        out_ack,
    output logic [P*VW-1:0]     out_vc,
    output logic [P*KW-1:0]     out_kind,
    output logic [P*DATA_W-1:0] out_data
);

    // Buffering to allocation.
    logic [P*V-1:0]        ivc_req;
    logic [P*V*PW-1:0]     ivc_dest;
    logic [P*V-1:0]        ivc_is_head;
    logic [P*V-1:0]        ivc_is_tail;
    logic [P*V-1:0]        ivc_ovc_assigned;
    logic [P*V*KW-1:0]     buf_kind;
    logic [P*V*DATA_W-1:0] buf_data;

    // Allocation back to buffering and on to the crossbar.
    logic [P*V-1:0]        sw_grant_ivc;
    logic [P*VW-1:0]       granted_ovc;
    logic [P-1:0]          xbar_sel_valid;
    logic [P*PW-1:0]       xbar_sel_in;
    logic [P*VW-1:0]       xbar_ovc;

    // Output stage back to allocation.
    logic [P-1:0]          out_busy;
    logic [P-1:0]          ovc_release_valid;
    logic [P*VW-1:0]       ovc_release_num;

    ivc_request_stage #(.P(P), .V(V), .DATA_W(DATA_W)) i_ivc (.*);

    combined_vc_sw_alloc #(.P(P), .V(V)) i_alloc (.*);

    crossbar_output_stage #(.P(P), .V(V), .DATA_W(DATA_W)) i_xbar (.*);

endmodule

//--- design/rr_arbiter.sv
`timescale 1ns/1ps

module rr_arbiter #(
    parameter int  N  = 4,
    localparam int IW = (N > 1) ? $clog2(N) : 1
) (
    input  logic         clk,
    input  logic         rst_n,
    input  logic [N-1:0] request,
    input  logic         accept,
    output logic [N-1:0] grant
);

    logic [IW-1:0] ptr;             // Highest priority requester.
    logic [IW-1:0] win_idx;

    // Search downwards so the first requester at or after ptr is kept.
    always_comb begin
        int idx;
        win_idx = '0;
        for (int k = N - 1; k >= 0; k--) begin
            idx = (int'(ptr) + k) % N;
            if (request[idx])
                win_idx = IW'(idx);
        end
        grant = '0;
        if (|request)
            grant[win_idx] = 1'b1;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ptr <= '0;
        end else if (accept && |request) begin
            ptr <= (int'(win_idx) == N - 1) ? '0 : win_idx + 1'b1;   // Winner goes last.
        end
    end

endmodule

//--- router_alloc.f
design/noc_flit_pkg.sv
design/noc_alloc_pkg.sv
design/rr_arbiter.sv
design/ivc_request_stage.sv
design/combined_vc_sw_alloc.sv
design/crossbar_output_stage.sv
design/router_alloc_top.sv
tests/router_alloc_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build the router testbench with Verilator and run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f router_alloc.f --top-module router_alloc_tb

output=$(./obj_dir/Vrouter_alloc_tb) || true
echo "$output"

if echo "$output" | grep -q "Everything OK"; then
    exit 0
fi
exit 1

//--- tests/router_alloc_tb.sv
`timescale 1ns/1ps

module router_alloc_tb;

    localparam int P         = 4;
    localparam int V         = 2;
    localparam int DATA_W    = 16;
    localparam int PW        = $clog2(P);
    localparam int VW        = $clog2(V);
    localparam int KW        = noc_flit_pkg::FLIT_KIND_W;
    localparam int NUM_FLITS = 19;              // Sum of flits over all tests.

    logic                clk;
    logic                rst_n;
    logic [P-1:0]        in_req;
    logic [P-1:0]        in_ack;
    logic [P*VW-1:0]     in_vc;
    logic [P*PW-1:0]     in_dest;
    logic [P*KW-1:0]     in_kind;
    logic [P*DATA_W-1:0] in_data;
    logic [P-1:0]        out_req;
    logic [P-1:0]        out_ack;
    logic [P*VW-1:0]     out_vc;
    logic [P*KW-1:0]     out_kind;
    logic [P*DATA_W-1:0] out_data;
    integer              seed;

    router_alloc_top #(.P(P), .V(V), .DATA_W(DATA_W)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic fail_run(input string line);
        $display("%s", line);
        $display("Something failed");
        $fatal(1, "simulation stopped");
    endtask

    function automatic logic [DATA_W-1:0] next_word();
        return DATA_W'($random(seed));
    endfunction

    // Four-phase send on one input port.
    task automatic send_flit(input int port, input int vc, input int dest,
                             input noc_flit_pkg::flit_kind_e kind,
                             input logic [DATA_W-1:0] data);
        @(negedge clk);
        in_vc[port*VW +: VW]           = VW'(vc);
        in_dest[port*PW +: PW]         = PW'(dest);
        in_kind[port*KW +: KW]         = kind;
        in_data[port*DATA_W +: DATA_W] = data;
        in_req[port]                   = 1'b1;
        while (!in_ack[port])
            @(negedge clk);                     // Longer while the buffer is full.
        in_req[port] = 1'b0;
        while (in_ack[port])
            @(negedge clk);
    endtask

    // Wait for a flit on one output port, check it, then acknowledge it.
    task automatic expect_flit(input int port, input int vc,
                               input noc_flit_pkg::flit_kind_e kind,
                               input logic [DATA_W-1:0] data);
        @(negedge clk);
        while (!out_req[port])
            @(negedge clk);
        assert (out_vc[port*VW +: VW] == VW'(vc) && out_kind[port*KW +: KW] == kind
                && out_data[port*DATA_W +: DATA_W] == data)
            else fail_run($sformatf("FAILED at %0t: port %0d got vc %0d kind %0d data %h, %s",
                $time, port, out_vc[port*VW +: VW], out_kind[port*KW +: KW],
                out_data[port*DATA_W +: DATA_W],
                $sformatf("expected vc %0d kind %0d data %h", vc, kind, data)));
        out_ack[port] = 1'b1;
        while (out_req[port])
            @(negedge clk);
        out_ack[port] = 1'b0;
    endtask

    task automatic expect_quiet(input int port, input int cycles);
        repeat (cycles) begin
            @(negedge clk);
            assert (!out_req[port])
                else fail_run($sformatf("FAILED at %0t: port %0d sent a flit with no free VC",
                    $time, port));
        end
    endtask

    // Withhold out_ack and watch the pending flit stay put.
    task automatic hold_and_check(input int port, input int cycles);
        logic [VW-1:0]     vc0;
        logic [KW-1:0]     kind0;
        logic [DATA_W-1:0] data0;
        while (!out_req[port])
            @(negedge clk);
        vc0   = out_vc[port*VW +: VW];
        kind0 = out_kind[port*KW +: KW];
        data0 = out_data[port*DATA_W +: DATA_W];
        repeat (cycles) begin
            @(negedge clk);
            assert (out_req[port] && out_vc[port*VW +: VW] == vc0
                    && out_kind[port*KW +: KW] == kind0
                    && out_data[port*DATA_W +: DATA_W] == data0)
                else fail_run($sformatf("FAILED at %0t: port %0d output moved without ack",
                    $time, port));
        end
    endtask

    task automatic reset_state();
        assert (out_req == '0 && in_ack == '0)
            else fail_run($sformatf("FAILED at %0t: out_req %b in_ack %b after reset",
                $time, out_req, in_ack));
    endtask

    task automatic single_flit_route();
        logic [DATA_W-1:0] d;
        d = next_word();
        send_flit(0, 1, 2, noc_flit_pkg::FLIT_SINGLE, d);
        expect_flit(2, 0, noc_flit_pkg::FLIT_SINGLE, d);    // Lowest free VC.
    endtask

    task automatic packet_order();
        logic [DATA_W-1:0] d [3];
        for (int i = 0; i < 3; i++)
            d[i] = next_word();
        fork
            begin
                send_flit(3, 0, 1, noc_flit_pkg::FLIT_HEAD, d[0]);
                send_flit(3, 0, 1, noc_flit_pkg::FLIT_BODY, d[1]);
                send_flit(3, 0, 1, noc_flit_pkg::FLIT_TAIL, d[2]);
            end
            begin
                expect_flit(1, 0, noc_flit_pkg::FLIT_HEAD, d[0]);
                expect_flit(1, 0, noc_flit_pkg::FLIT_BODY, d[1]);
                expect_flit(1, 0, noc_flit_pkg::FLIT_TAIL, d[2]);
            end
        join
    endtask

    task automatic interleaved_packets();
        logic [DATA_W-1:0] a [3];
        logic [DATA_W-1:0] b [3];
        for (int i = 0; i < 3; i++) begin
            a[i] = next_word();
            b[i] = next_word();
        end
        send_flit(1, 0, 0, noc_flit_pkg::FLIT_HEAD, a[0]);
        expect_flit(0, 0, noc_flit_pkg::FLIT_HEAD, a[0]);
        send_flit(3, 1, 0, noc_flit_pkg::FLIT_HEAD, b[0]);
        expect_flit(0, 1, noc_flit_pkg::FLIT_HEAD, b[0]);   // VC 0 is held open.
        send_flit(1, 0, 0, noc_flit_pkg::FLIT_BODY, a[1]);
        expect_flit(0, 0, noc_flit_pkg::FLIT_BODY, a[1]);
        send_flit(3, 1, 0, noc_flit_pkg::FLIT_BODY, b[1]);
        expect_flit(0, 1, noc_flit_pkg::FLIT_BODY, b[1]);
        send_flit(1, 0, 0, noc_flit_pkg::FLIT_TAIL, a[2]);
        expect_flit(0, 0, noc_flit_pkg::FLIT_TAIL, a[2]);
        send_flit(3, 1, 0, noc_flit_pkg::FLIT_TAIL, b[2]);
        expect_flit(0, 1, noc_flit_pkg::FLIT_TAIL, b[2]);
    endtask

    task automatic vc_exhaustion();
        logic [DATA_W-1:0] d [6];
        for (int i = 0; i < 6; i++)
            d[i] = next_word();
        send_flit(0, 0, 2, noc_flit_pkg::FLIT_HEAD, d[0]);
        expect_flit(2, 0, noc_flit_pkg::FLIT_HEAD, d[0]);
        send_flit(1, 0, 2, noc_flit_pkg::FLIT_HEAD, d[1]);
        expect_flit(2, 1, noc_flit_pkg::FLIT_HEAD, d[1]);
        send_flit(3, 0, 2, noc_flit_pkg::FLIT_HEAD, d[2]);  // Both VCs of port 2 taken.
        expect_quiet(2, 8);
        send_flit(1, 0, 2, noc_flit_pkg::FLIT_TAIL, d[3]);
        expect_flit(2, 1, noc_flit_pkg::FLIT_TAIL, d[3]);
        expect_flit(2, 1, noc_flit_pkg::FLIT_HEAD, d[2]);   // Takes the freed VC.
        send_flit(0, 0, 2, noc_flit_pkg::FLIT_TAIL, d[4]);
        expect_flit(2, 0, noc_flit_pkg::FLIT_TAIL, d[4]);
        send_flit(3, 0, 2, noc_flit_pkg::FLIT_TAIL, d[5]);
        expect_flit(2, 1, noc_flit_pkg::FLIT_TAIL, d[5]);
    endtask

    task automatic back_pressure();
        logic [DATA_W-1:0] d [3];
        for (int i = 0; i < 3; i++)
            d[i] = next_word();
        fork
            begin
                send_flit(2, 1, 1, noc_flit_pkg::FLIT_HEAD, d[0]);
                send_flit(2, 1, 1, noc_flit_pkg::FLIT_BODY, d[1]);
                send_flit(2, 1, 1, noc_flit_pkg::FLIT_TAIL, d[2]);
            end
            begin
                hold_and_check(1, 12);
                expect_flit(1, 0, noc_flit_pkg::FLIT_HEAD, d[0]);
                expect_flit(1, 0, noc_flit_pkg::FLIT_BODY, d[1]);
                expect_flit(1, 0, noc_flit_pkg::FLIT_TAIL, d[2]);
            end
        join
    endtask

    initial begin
        seed    = 32'he93586cd;
        rst_n   = 1'b0;
        in_req  = '0;
        in_vc   = '0;
        in_dest = '0;
        in_kind = '0;
        in_data = '0;
        out_ack = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        reset_state();
        single_flit_route();
        packet_order();
        interleaved_packets();
        vc_exhaustion();
        back_pressure();
        $display("Everything OK");
        $finish;
    end

    // Generous budget of 40 cycles per flit.
    initial begin
        repeat (NUM_FLITS * 40) @(posedge clk);
        fail_run("Timeout: the router stopped moving flits before the tests finished");
    end

endmodule
